// ==== Makefile ====
TOP = ceu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== ceu_ctrl/ceu_ctrl.sv ====
`timescale 1ns/1ps

module ceu_ctrl
    import ceu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // host command register
    input  logic        hcr_go,
    input  mbox_addr_t  hcr_in_param,
    input  mbox_addr_t  hcr_out_dma_addr,
    input  in_mod_t     hcr_in_modifier,
    input  op_mod_t     hcr_op_modifier,
    input  op_t         hcr_op,

    // decode results
    input  exe_target_e target,
    input  logic        has_outbox,
    input  logic        bad_op,
    input  logic        bad_modifier,
    input  byte_len_t   inbox_len,

    // captured fields to the decode parts
    output op_t         reg_op,
    output op_mod_t     reg_op_modifier,
    output in_mod_t     reg_in_modifier,

    output hcr_status_t hcr_status,
    output logic        hcr_clear,

    // inbox read request, single beat
    output logic        dma_rd_req_valid,
    output dma_head_t   dma_rd_req_head,
    input  logic        dma_rd_req_ready,

    // execute levels, one hot
    output logic        exe_local,
    output logic        exe_cm,
    output logic        exe_v2p,
    output logic        exe_both,
    input  logic        exe_done
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    mbox_addr_t  reg_in_param;
    mbox_addr_t  reg_out_dma_addr;
    logic        has_inbox;
    logic        bad_param;
    logic        in_decode;
    logic        in_execute;

    assign in_decode  = (state == ST_DECODE);
    assign in_execute = (state == ST_EXECUTE);
    assign has_inbox  = |inbox_len;

    // ************************************************************
    // status and clear
    // ************************************************************
    assign bad_param = bad_modifier
                     | (has_inbox  & (reg_in_param == '0))      // inbox without address
                     | (has_outbox & (reg_out_dma_addr == '0)); // outbox without address

    always_comb begin
        hcr_status = STAT_OK;
        if (in_decode) begin  // status only shown in decode
            if (bad_op)
                hcr_status = hcr_status | STAT_BAD_OP;
            if (bad_param)
                hcr_status = hcr_status | STAT_BAD_PARAM;
        end
    end

    // error in decode, or target finished
    assign hcr_clear = (in_decode & (|hcr_status)) | (in_execute & exe_done);

    // ************************************************************
    // command registers
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_op           <= '0;
            reg_op_modifier  <= '0;
            reg_in_modifier  <= '0;
            reg_in_param     <= '0;
            reg_out_dma_addr <= '0;
        end else if (hcr_clear) begin  // command retired
            reg_op           <= '0;
            reg_op_modifier  <= '0;
            reg_in_modifier  <= '0;
            reg_in_param     <= '0;
            reg_out_dma_addr <= '0;
        end else if ((state == ST_IDLE) && hcr_go) begin
            reg_op           <= hcr_op;
            reg_op_modifier  <= hcr_op_modifier;
            reg_in_modifier  <= hcr_in_modifier;
            reg_in_param     <= hcr_in_param;
            reg_out_dma_addr <= hcr_out_dma_addr;
        end
    end

    // ************************************************************
    // FSM
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (hcr_go)
                    state_nxt = ST_DECODE;  // go ignored elsewhere
            end
            ST_DECODE: begin
                if (|hcr_status)
                    state_nxt = ST_IDLE;
                else if (has_inbox)
                    state_nxt = ST_GET_INBOX;
                else
                    state_nxt = ST_EXECUTE;
            end
            ST_GET_INBOX: begin
                if (dma_rd_req_ready)  // valid is high all through this state
                    state_nxt = ST_EXECUTE;
            end
            ST_EXECUTE: begin
                if (exe_done)
                    state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // head is stable while waiting, regs do not move in this state
    assign dma_rd_req_valid = (state == ST_GET_INBOX);
    assign dma_rd_req_head  = dma_rd_req_valid ? {32'd0, reg_in_param, 20'd0, inbox_len} : '0;

    // target held until done
    assign exe_local = in_execute & (target == TGT_LOCAL);
    assign exe_cm    = in_execute & (target == TGT_CM);
    assign exe_v2p   = in_execute & (target == TGT_V2P);
    assign exe_both  = in_execute & (target == TGT_BOTH);

endmodule

// ==== common/ceu_pkg.sv ====
package ceu_pkg;

    // ************************************************************
    // field widths
    // ************************************************************
    localparam int OP_W       = 12;
    localparam int OP_MOD_W   = 8;
    localparam int IN_MOD_W   = 32;
    localparam int ADDR_W     = 64;  // host mailbox address
    localparam int LEN_W      = 12;  // inbox length in bytes
    localparam int STATUS_W   = 8;
    localparam int DMA_HEAD_W = 128;

    typedef logic [OP_W-1:0]       op_t;
    typedef logic [OP_MOD_W-1:0]   op_mod_t;
    typedef logic [IN_MOD_W-1:0]   in_mod_t;
    typedef logic [ADDR_W-1:0]     mbox_addr_t;
    typedef logic [LEN_W-1:0]      byte_len_t;
    typedef logic [STATUS_W-1:0]   hcr_status_t;
    typedef logic [DMA_HEAD_W-1:0] dma_head_t;  // addr at 95:32, len at 11:0

    // which execution unit takes the command
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_LOCAL,  // local access
        TGT_CM,     // context management
        TGT_V2P,    // virtual to physical
        TGT_BOTH    // cm and v2p together
    } exe_target_e;

    // controller FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECODE,
        ST_GET_INBOX,
        ST_EXECUTE
    } ctrl_state_e;

    // ************************************************************
    // opcodes
    // ************************************************************
    localparam op_t CMD_QUERY_DEV_LIM   = 12'h003;
    localparam op_t CMD_QUERY_ADAPTER   = 12'h006;
    localparam op_t CMD_INIT_HCA        = 12'h007;
    localparam op_t CMD_CLOSE_HCA       = 12'h008;
    localparam op_t CMD_SW2HW_MPT       = 12'h00D;
    localparam op_t CMD_HW2SW_MPT       = 12'h00F;
    localparam op_t CMD_WRITE_MTT       = 12'h011;
    localparam op_t CMD_MAP_EQ          = 12'h012;
    localparam op_t CMD_SW2HW_EQ        = 12'h013;
    localparam op_t CMD_HW2SW_EQ        = 12'h014;
    localparam op_t CMD_SW2HW_CQ        = 12'h016;
    localparam op_t CMD_HW2SW_CQ        = 12'h017;
    localparam op_t CMD_MODIFY_QP_FIRST = 12'h019;  // modify-qp range, inclusive
    localparam op_t CMD_MODIFY_QP_LAST  = 12'h021;
    localparam op_t CMD_QUERY_QP        = 12'h022;
    localparam op_t CMD_MAD_IFC         = 12'h024;
    localparam op_t CMD_RESIZE_CQ       = 12'h02C;
    localparam op_t CMD_UNMAP_ICM       = 12'hFF9;
    localparam op_t CMD_MAP_ICM         = 12'hFFA;

    // op modifier picks the unit for map/unmap icm
    localparam op_mod_t ICM_IN_CM  = 8'd1;
    localparam op_mod_t ICM_IN_V2P = 8'd2;

    // status codes, ored together on error
    localparam hcr_status_t STAT_OK        = 8'h00;
    localparam hcr_status_t STAT_BAD_OP    = 8'h02;
    localparam hcr_status_t STAT_BAD_PARAM = 8'h03;

    // fixed inbox sizes in bytes
    localparam byte_len_t INBOX_LEN_INIT_HCA  = 12'd256;
    localparam byte_len_t INBOX_LEN_MODIFY_QP = 12'd256;
    localparam byte_len_t INBOX_LEN_SW2HW_CQ  = 12'd64;
    localparam byte_len_t INBOX_LEN_RESIZE_CQ = 12'd64;
    localparam byte_len_t INBOX_LEN_SW2HW_EQ  = 12'd64;
    localparam byte_len_t INBOX_LEN_SW2HW_MPT = 12'd64;

    localparam byte_len_t INBOX_UNIT_BYTES = 12'd32;  // icm / mtt size step

endpackage

// ==== files.f ====
common/ceu_pkg.sv
hdl/op_decoder.sv
hdl/inbox_sizer.sv
ceu_ctrl/ceu_ctrl.sv
hdl/ceu_top.sv
test/ceu_tb.sv

// ==== hdl/ceu_top.sv ====
`timescale 1ns/1ps

module ceu_top
    import ceu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // host command register
    input  mbox_addr_t  hcr_in_param,
    input  in_mod_t     hcr_in_modifier,
    input  mbox_addr_t  hcr_out_dma_addr,
    input  logic        hcr_go,
    input  op_mod_t     hcr_op_modifier,
    input  op_t         hcr_op,
    output hcr_status_t hcr_status,
    output logic        hcr_clear,

    // dma read request
    output logic        dma_rd_req_valid,
    output dma_head_t   dma_rd_req_head,
    input  logic        dma_rd_req_ready,

    // execution units
    output logic        exe_local,
    output logic        exe_cm,
    output logic        exe_v2p,
    output logic        exe_both,
    input  logic        exe_done
);

    op_t         reg_op;
    op_mod_t     reg_op_modifier;
    in_mod_t     reg_in_modifier;
    exe_target_e target;
    logic        has_outbox;
    logic        bad_op;
    logic        bad_modifier;
    byte_len_t   inbox_len;

    // ************************************************************
    // decode parts, both fed from the captured command
    // ************************************************************
    op_decoder u_op_decoder (
        .op           (reg_op),
        .op_mod       (reg_op_modifier),
        .target       (target),
        .has_outbox   (has_outbox),
        .bad_op       (bad_op),
        .bad_modifier (bad_modifier)
    );

    inbox_sizer u_inbox_sizer (
        .op        (reg_op),
        .op_mod    (reg_op_modifier),
        .in_mod    (reg_in_modifier),
        .inbox_len (inbox_len)       // zero when no inbox
    );

    ceu_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .hcr_go           (hcr_go),
        .hcr_in_param     (hcr_in_param),
        .hcr_out_dma_addr (hcr_out_dma_addr),
        .hcr_in_modifier  (hcr_in_modifier),
        .hcr_op_modifier  (hcr_op_modifier),
        .hcr_op           (hcr_op),
        .target           (target),
        .has_outbox       (has_outbox),
        .bad_op           (bad_op),
        .bad_modifier     (bad_modifier),
        .inbox_len        (inbox_len),
        .reg_op           (reg_op),
        .reg_op_modifier  (reg_op_modifier),
        .reg_in_modifier  (reg_in_modifier),
        .hcr_status       (hcr_status),
        .hcr_clear        (hcr_clear),
        .dma_rd_req_valid (dma_rd_req_valid),
        .dma_rd_req_head  (dma_rd_req_head),
        .dma_rd_req_ready (dma_rd_req_ready),
        .exe_local        (exe_local),
        .exe_cm           (exe_cm),
        .exe_v2p          (exe_v2p),
        .exe_both         (exe_both),
        .exe_done         (exe_done)
    );

endmodule

// ==== hdl/inbox_sizer.sv ====
`timescale 1ns/1ps

module inbox_sizer
    import ceu_pkg::*;
(
    input  op_t       op,
    input  op_mod_t   op_mod,
    input  in_mod_t   in_mod,
    output byte_len_t inbox_len
);

    logic      is_modify_qp;
    byte_len_t map_icm_units;    // 32-byte units for map icm
    byte_len_t write_mtt_units;  // 32-byte units for write mtt

    assign is_modify_qp = (op >= CMD_MODIFY_QP_FIRST) && (op <= CMD_MODIFY_QP_LAST);

    // page count halved, rounded up
    assign map_icm_units = byte_len_t'(in_mod[7:1]) + byte_len_t'(in_mod[0]);

    // entries in groups of four, partial group rounds up, plus header unit
    assign write_mtt_units = byte_len_t'(in_mod[7:2]) + byte_len_t'(|in_mod[1:0])
                           + byte_len_t'(1);

    // ************************************************************
    // length table, zero means no inbox
    // ************************************************************
    always_comb begin
        case (op)
            CMD_INIT_HCA:  inbox_len = INBOX_LEN_INIT_HCA;
            CMD_SW2HW_CQ:  inbox_len = INBOX_LEN_SW2HW_CQ;
            CMD_RESIZE_CQ: inbox_len = INBOX_LEN_RESIZE_CQ;
            CMD_SW2HW_EQ:  inbox_len = INBOX_LEN_SW2HW_EQ;
            CMD_SW2HW_MPT: inbox_len = INBOX_LEN_SW2HW_MPT;
            CMD_MAP_ICM:   inbox_len = map_icm_units * INBOX_UNIT_BYTES;
            CMD_WRITE_MTT: inbox_len = write_mtt_units * INBOX_UNIT_BYTES;
            default: begin
                // modify qp carries a context only with modifier 0
                if (is_modify_qp && (op_mod == 8'd0))
                    inbox_len = INBOX_LEN_MODIFY_QP;
                else
                    inbox_len = '0;
            end
        endcase
    end

endmodule

// ==== hdl/op_decoder.sv ====
`timescale 1ns/1ps

module op_decoder
    import ceu_pkg::*;
(
    input  op_t         op,
    input  op_mod_t     op_mod,
    output exe_target_e target,
    output logic        has_outbox,
    output logic        bad_op,
    output logic        bad_modifier
);

    logic is_modify_qp;  // whole modify-qp opcode range
    logic icm_sel_ok;    // icm modifier names a unit

    assign is_modify_qp = (op >= CMD_MODIFY_QP_FIRST) && (op <= CMD_MODIFY_QP_LAST);
    assign icm_sel_ok   = (op_mod == ICM_IN_CM) || (op_mod == ICM_IN_V2P);

    // ************************************************************
    // opcode classification
    // ************************************************************
    always_comb begin
        target       = TGT_NONE;
        has_outbox   = 1'b0;
        bad_op       = 1'b0;
        bad_modifier = 1'b0;

        if (is_modify_qp) begin
            target       = TGT_CM;
            bad_modifier = !(op_mod inside {8'd0, 8'd2, 8'd3});  // only 0, 2, 3 allowed
        end else begin
            case (op)
                // local access
                CMD_QUERY_DEV_LIM,
                CMD_QUERY_ADAPTER: begin
                    target     = TGT_LOCAL;
                    has_outbox = 1'b1;
                end
                CMD_MAD_IFC: begin
                    target       = TGT_LOCAL;
                    has_outbox   = 1'b1;
                    bad_modifier = (op_mod != 8'd1);
                end
                // context management
                CMD_SW2HW_CQ, CMD_RESIZE_CQ, CMD_SW2HW_EQ,
                CMD_MAP_EQ, CMD_HW2SW_CQ, CMD_HW2SW_EQ: begin
                    target = TGT_CM;
                end
                CMD_QUERY_QP: begin
                    target     = TGT_CM;
                    has_outbox = 1'b1;  // qp context goes back to host
                end
                // virtual to physical
                CMD_SW2HW_MPT, CMD_WRITE_MTT, CMD_HW2SW_MPT: begin
                    target = TGT_V2P;
                end
                // both units
                CMD_INIT_HCA, CMD_CLOSE_HCA: begin
                    target = TGT_BOTH;
                end
                // icm ops route by modifier
                CMD_MAP_ICM, CMD_UNMAP_ICM: begin
                    bad_modifier = !icm_sel_ok;
                    if (op_mod == ICM_IN_CM)
                        target = TGT_CM;
                    else if (op_mod == ICM_IN_V2P)
                        target = TGT_V2P;
                end
                default: begin
                    bad_op = 1'b1;  // unknown or unrealized op
                end
            endcase
        end
    end

endmodule

// ==== test/ceu_tb.sv ====
`timescale 1ns/1ps

module ceu_tb;
    import ceu_pkg::*;

    localparam int TIMEOUT = 200;  // cycles allowed per wait

    logic        clk;
    logic        rst_n;
    mbox_addr_t  hcr_in_param;
    in_mod_t     hcr_in_modifier;
    mbox_addr_t  hcr_out_dma_addr;
    logic        hcr_go;
    op_mod_t     hcr_op_modifier;
    op_t         hcr_op;
    hcr_status_t hcr_status;
    logic        hcr_clear;
    logic        dma_rd_req_valid;
    dma_head_t   dma_rd_req_head;
    logic        dma_rd_req_ready;
    logic        exe_local;
    logic        exe_cm;
    logic        exe_v2p;
    logic        exe_both;
    logic        exe_done;

    ceu_top dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    // ************************************************************
    // reporting and compare
    // ************************************************************
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "first error ends the run");
    endtask

    task automatic level_is(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic status_is(input hcr_status_t got, input hcr_status_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %0t hcr_status got %h expected %h",
                                    $time, got, exp));
    endtask

    task automatic head_is(input dma_head_t got, input dma_head_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %0t dma_rd_req_head got %h expected %h",
                                    $time, got, exp));
    endtask

    // target rebuilt from the four execute levels
    task automatic target_is(input exe_target_e exp);
        exe_target_e got;
        if ($countones({exe_local, exe_cm, exe_v2p, exe_both}) > 1)
            stop_on_error($sformatf("more than one execute level is high at %0t", $time));
        got = exe_local ? TGT_LOCAL :
              exe_cm    ? TGT_CM    :
              exe_v2p   ? TGT_V2P   :
              exe_both  ? TGT_BOTH  : TGT_NONE;
        if (got !== exp)
            stop_on_error($sformatf("FAILED %0t exe target got %s expected %s",
                                    $time, got.name(), exp.name()));
    endtask

    // ************************************************************
    // expected values from the command rules
    // ************************************************************
    function automatic dma_head_t expected_head(input mbox_addr_t addr, input byte_len_t len);
        dma_head_t h;
        h = '0;
        h[95:32] = addr;
        h[11:0]  = len;
        return h;
    endfunction

    function automatic byte_len_t icm_bytes(input int pages);
        return byte_len_t'(((pages + 1) / 2) * 32);  // two pages per 32-byte unit
    endfunction

    function automatic byte_len_t mtt_bytes(input int entries);
        return byte_len_t'(((entries + 3) / 4 + 1) * 32);  // groups of four plus header
    endfunction

    function automatic mbox_addr_t random_addr();
        return {$urandom, $urandom | 32'h1};  // never zero
    endfunction

    // ************************************************************
    // drive and wait helpers
    // ************************************************************
    task automatic to_drive_point;
        @(posedge clk);
        #1;
    endtask

    task automatic send_command(input op_t op, input op_mod_t mod, input in_mod_t in_mod,
                                input mbox_addr_t in_param, input mbox_addr_t out_addr);
        hcr_op           = op;
        hcr_op_modifier  = mod;
        hcr_in_modifier  = in_mod;
        hcr_in_param     = in_param;
        hcr_out_dma_addr = out_addr;
        hcr_go           = 1'b1;
        to_drive_point();
        hcr_go           = 1'b0;  // unit now in decode
    endtask

    // decode error shows in the decode cycle, then nothing follows
    task automatic expect_reject(input op_t op, input op_mod_t mod, input mbox_addr_t in_param,
                                 input mbox_addr_t out_addr, input hcr_status_t exp);
        send_command(op, mod, 32'd0, in_param, out_addr);
        @(negedge clk);
        level_is("hcr_clear", hcr_clear, 1'b1);
        status_is(hcr_status, exp);
        target_is(TGT_NONE);  // nothing dispatched from decode
        repeat (3) begin
            @(negedge clk);
            level_is("hcr_clear", hcr_clear, 1'b0);
            status_is(hcr_status, STAT_OK);  // status only shown in decode
            level_is("dma_rd_req_valid", dma_rd_req_valid, 1'b0);
            target_is(TGT_NONE);
        end
        to_drive_point();
    endtask

    task automatic serve_inbox(input dma_head_t exp, input int stall);
        int n;
        n = 0;
        @(negedge clk);
        while (!dma_rd_req_valid) begin
            target_is(TGT_NONE);
            n++;
            if (n >= TIMEOUT)
                stop_on_error("timeout waiting for the DMA read request");
            @(negedge clk);
        end
        head_is(dma_rd_req_head, exp);
        target_is(TGT_NONE);  // execute only after the read
        repeat (stall) begin  // back-pressure, request must hold
            to_drive_point();
            @(negedge clk);
            level_is("dma_rd_req_valid", dma_rd_req_valid, 1'b1);
            head_is(dma_rd_req_head, exp);
            target_is(TGT_NONE);
        end
        to_drive_point();
        dma_rd_req_ready = 1'b1;
        @(negedge clk);
        level_is("dma_rd_req_valid", dma_rd_req_valid, 1'b1);
        to_drive_point();
        dma_rd_req_ready = 1'b0;
    endtask

    // poke sends a second go during execute, which must be ignored
    task automatic finish_execute(input exe_target_e exp, input int hold, input bit poke);
        int n;
        n = 0;
        @(negedge clk);
        while (!(exe_local | exe_cm | exe_v2p | exe_both)) begin
            level_is("hcr_clear", hcr_clear, 1'b0);
            level_is("dma_rd_req_valid", dma_rd_req_valid, 1'b0);
            n++;
            if (n >= TIMEOUT)
                stop_on_error("timeout waiting for an execute level");
            @(negedge clk);
        end
        target_is(exp);
        for (int i = 0; i < hold; i++) begin
            to_drive_point();
            hcr_go = poke && (i == 0);
            if (poke)
                hcr_op = CMD_CLOSE_HCA;
            @(negedge clk);
            target_is(exp);
            level_is("hcr_clear", hcr_clear, 1'b0);
        end
        to_drive_point();
        hcr_go   = 1'b0;
        exe_done = 1'b1;
        @(negedge clk);
        level_is("hcr_clear", hcr_clear, 1'b1);
        status_is(hcr_status, STAT_OK);
        to_drive_point();
        exe_done = 1'b0;
        @(negedge clk);
        target_is(TGT_NONE);  // back in idle
        level_is("hcr_clear", hcr_clear, 1'b0);
        to_drive_point();
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic reject_unknown_op;
        expect_reject(12'h123, 8'd0, random_addr(), random_addr(), STAT_BAD_OP);
    endtask

    task automatic reject_bad_params;
        expect_reject(CMD_MAP_ICM, 8'd3, random_addr(), 64'd0, STAT_BAD_PARAM);
        expect_reject(CMD_QUERY_QP, 8'd0, random_addr(), 64'd0, STAT_BAD_PARAM);
        expect_reject(CMD_SW2HW_CQ, 8'd0, 64'd0, random_addr(), STAT_BAD_PARAM);
        expect_reject(CMD_MAD_IFC, 8'd0, random_addr(), random_addr(), STAT_BAD_PARAM);
    endtask

    task automatic inbox_with_backpressure;
        mbox_addr_t addr;
        addr = random_addr();
        send_command(CMD_SW2HW_CQ, 8'd0, 32'd0, addr, 64'd0);
        serve_inbox(expected_head(addr, 12'd64), int'($urandom % 11));
        finish_execute(TGT_CM, 3, 1'b0);
    endtask

    task automatic inbox_lengths;
        mbox_addr_t addr;
        int         pages;
        repeat (3) begin
            addr  = random_addr();
            pages = 1 + int'($urandom % 250);  // keeps the length inside 12 bits
            send_command(CMD_MAP_ICM, ICM_IN_V2P, in_mod_t'(pages), addr, 64'd0);
            serve_inbox(expected_head(addr, icm_bytes(pages)), int'($urandom % 4));
            finish_execute(TGT_V2P, 1, 1'b0);
            addr  = random_addr();
            pages = int'($urandom % 256);
            send_command(CMD_WRITE_MTT, 8'd0, in_mod_t'(pages), addr, 64'd0);
            serve_inbox(expected_head(addr, mtt_bytes(pages)), int'($urandom % 4));
            finish_execute(TGT_V2P, 1, 1'b0);
        end
        addr = random_addr();
        send_command(12'h01C, 8'd0, 32'd0, addr, 64'd0);  // modify-qp, mid range
        serve_inbox(expected_head(addr, 12'd256), 0);
        finish_execute(TGT_CM, 1, 1'b0);
        send_command(12'h01C, 8'd2, 32'd0, addr, 64'd0);  // no inbox with modifier 2
        finish_execute(TGT_CM, 1, 1'b0);
    endtask

    task automatic dispatch_no_inbox;
        send_command(CMD_QUERY_DEV_LIM, 8'd0, 32'd0, 64'd0, random_addr());
        finish_execute(TGT_LOCAL, 2, 1'b0);
        send_command(CMD_QUERY_QP, 8'd0, 32'd0, 64'd0, random_addr());
        finish_execute(TGT_CM, 2, 1'b0);
        send_command(CMD_HW2SW_MPT, 8'd0, 32'd0, 64'd0, 64'd0);
        finish_execute(TGT_V2P, 2, 1'b0);
        send_command(CMD_UNMAP_ICM, ICM_IN_V2P, 32'd0, 64'd0, 64'd0);
        finish_execute(TGT_V2P, 2, 1'b0);
        send_command(CMD_CLOSE_HCA, 8'd0, 32'd0, 64'd0, 64'd0);
        finish_execute(TGT_BOTH, 2, 1'b0);
    endtask

    task automatic ignore_go_when_busy;
        send_command(CMD_QUERY_DEV_LIM, 8'd0, 32'd0, 64'd0, random_addr());
        finish_execute(TGT_LOCAL, 4, 1'b1);
        send_command(CMD_HW2SW_MPT, 8'd0, 32'd0, 64'd0, 64'd0);  // accepted again
        finish_execute(TGT_V2P, 1, 1'b0);
    endtask

    // ************************************************************
    // run
    // ************************************************************
    initial begin
        void'($urandom(32'h86a0));
        rst_n            = 1'b0;
        hcr_in_param     = '0;
        hcr_in_modifier  = '0;
        hcr_out_dma_addr = '0;
        hcr_go           = 1'b0;
        hcr_op_modifier  = '0;
        hcr_op           = '0;
        dma_rd_req_ready = 1'b0;
        exe_done         = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        level_is("hcr_clear", hcr_clear, 1'b0);
        level_is("dma_rd_req_valid", dma_rd_req_valid, 1'b0);
        head_is(dma_rd_req_head, '0);
        target_is(TGT_NONE);
        to_drive_point();

        reject_unknown_op();
        reject_bad_params();
        inbox_with_backpressure();
        inbox_lengths();
        dispatch_no_inbox();
        ignore_go_when_busy();

        $display("Finished with no errors");
        $finish;
    end

endmodule
